/* run_sim.sh */
#!/usr/bin/env bash
# Builds and runs the testbench with Verilator; exit status follows the log result

cd "$(dirname "$0")" || exit 1
log_file=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
	--top-module tb_zx_mem -f sim.f -o tb_zx_mem
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_zx_mem > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -qx 'All tests passed!' "$log_file"; then
	exit 0
fi
exit 1

/* sim.f */
+incdir+.
zx_io_pkg.sv
zx_mem_pkg.sv
zx_bus_decode.sv
zx_port_regs.sv
zx_mem_map.sv
zx_mem_top.sv
tb_zx_mem.sv

/* tb_zx_mem_table.svh */
// Rows run in order and rely on paging and FE state left by earlier rows until the next reset
// reset, model, cycle, addr, data, ram_addr, ram_we, border, ear, mic, page_scr
localparam int NUM_ROWS = 29;

localparam row_t ROWS [NUM_ROWS] = '{
	'{1'b1, model_128, cyc_mem_rd, 16'h0123, 8'h00, 20'h80123, 1'b0, 3'd0, 1'b0, 1'b0, 1'b0},
	'{1'b0, model_128, cyc_mem_rd, 16'h4567, 8'h00, 20'h14567, 1'b0, 3'd0, 1'b0, 1'b0, 1'b0},
	'{1'b0, model_128, cyc_mem_rd, 16'h89AB, 8'h00, 20'h089AB, 1'b0, 3'd0, 1'b0, 1'b0, 1'b0},
	'{1'b0, model_128, cyc_mem_rd, 16'hCDEF, 8'h00, 20'h00DEF, 1'b0, 3'd0, 1'b0, 1'b0, 1'b0},
	'{1'b0, model_128, cyc_mem_wr, 16'h1000, 8'h00, 20'h81000, 1'b0, 3'd0, 1'b0, 1'b0, 1'b0},
	'{1'b0, model_128, cyc_io_wr,  16'h7FFD, 8'h1E, 20'h00000, 1'b0, 3'd0, 1'b0, 1'b0, 1'b1},
	'{1'b0, model_128, cyc_mem_rd, 16'hC100, 8'h00, 20'h18100, 1'b0, 3'd0, 1'b0, 1'b0, 1'b1},
	'{1'b0, model_128, cyc_mem_rd, 16'h0200, 8'h00, 20'h84200, 1'b0, 3'd0, 1'b0, 1'b0, 1'b1},
	'{1'b0, model_128, cyc_io_wr,  16'h7FFD, 8'h23, 20'h00000, 1'b0, 3'd0, 1'b0, 1'b0, 1'b0},
	'{1'b0, model_128, cyc_io_wr,  16'h7FFD, 8'h17, 20'h00000, 1'b0, 3'd0, 1'b0, 1'b0, 1'b0},
	'{1'b0, model_128, cyc_mem_rd, 16'hC000, 8'h00, 20'h0C000, 1'b0, 3'd0, 1'b0, 1'b0, 1'b0},
	// Reset clears the lock
	'{1'b1, model_128, cyc_io_wr,  16'h7FFD, 8'h07, 20'h00000, 1'b0, 3'd0, 1'b0, 1'b0, 1'b0},
	'{1'b0, model_128, cyc_mem_rd, 16'hC000, 8'h00, 20'h1C000, 1'b0, 3'd0, 1'b0, 1'b0, 1'b0},
	'{1'b0, model_128, cyc_io_wr,  16'h00FE, 8'h15, 20'h00000, 1'b0, 3'd5, 1'b1, 1'b0, 1'b0},
	// +3 special layouts 0 to 3
	'{1'b1, model_plus3, cyc_io_wr,  16'h1FFD, 8'h01, 20'h00000, 1'b0, 3'd0, 1'b0, 1'b0, 1'b0},
	'{1'b0, model_plus3, cyc_mem_wr, 16'h0010, 8'h00, 20'h00010, 1'b1, 3'd0, 1'b0, 1'b0, 1'b0},
	'{1'b0, model_plus3, cyc_io_wr,  16'h1FFD, 8'h03, 20'h00000, 1'b0, 3'd0, 1'b0, 1'b0, 1'b0},
	'{1'b0, model_plus3, cyc_mem_wr, 16'h0020, 8'h00, 20'h10020, 1'b1, 3'd0, 1'b0, 1'b0, 1'b0},
	'{1'b0, model_plus3, cyc_io_wr,  16'h1FFD, 8'h05, 20'h00000, 1'b0, 3'd0, 1'b0, 1'b0, 1'b0},
	'{1'b0, model_plus3, cyc_mem_rd, 16'hC030, 8'h00, 20'h0C030, 1'b0, 3'd0, 1'b0, 1'b0, 1'b0},
	'{1'b0, model_plus3, cyc_io_wr,  16'h1FFD, 8'h07, 20'h00000, 1'b0, 3'd0, 1'b0, 1'b0, 1'b0},
	'{1'b0, model_plus3, cyc_mem_rd, 16'h4040, 8'h00, 20'h1C040, 1'b0, 3'd0, 1'b0, 1'b0, 1'b0},
	'{1'b0, model_plus3, cyc_io_wr,  16'h1FFD, 8'h04, 20'h00000, 1'b0, 3'd0, 1'b0, 1'b0, 1'b0},
	'{1'b0, model_plus3, cyc_io_wr,  16'h7FFD, 8'h10, 20'h00000, 1'b0, 3'd0, 1'b0, 1'b0, 1'b0},
	'{1'b0, model_plus3, cyc_mem_wr, 16'h0060, 8'h00, 20'h8C060, 1'b0, 3'd0, 1'b0, 1'b0, 1'b0},
	// 48K ignores 7FFD
	'{1'b1, model_48, cyc_io_wr,  16'h7FFD, 8'h07, 20'h00000, 1'b0, 3'd0, 1'b0, 1'b0, 1'b0},
	'{1'b0, model_48, cyc_mem_rd, 16'hC000, 8'h00, 20'h00000, 1'b0, 3'd0, 1'b0, 1'b0, 1'b0},
	'{1'b0, model_48, cyc_mem_wr, 16'h0100, 8'h00, 20'h84100, 1'b0, 3'd0, 1'b0, 1'b0, 1'b0},
	'{1'b0, model_48, cyc_io_wr,  16'hFFFE, 8'h1F, 20'h00000, 1'b0, 3'd7, 1'b1, 1'b1, 1'b0}
};

/* tb_zx_mem.sv */
// Fixed table of bus cycles, each held four clocks and checked in the last; no random stimulus
`timescale 1ns/1ns

module tb_zx_mem import zx_io_pkg::*, zx_mem_pkg::*; ();

	typedef enum logic [1:0] {
		cyc_idle,
		cyc_io_wr,
		cyc_mem_rd,
		cyc_mem_wr
	} cyc_t;

	typedef struct packed {
		logic        do_reset;   // Reset with this row's model first
		model_t      model;
		cyc_t        cyc;
		logic [15:0] addr;
		logic [7:0]  data;
		phys_addr_t  exp_addr;   // Checked on memory cycles only
		logic        exp_we;
		logic [2:0]  exp_border;
		logic        exp_ear;
		logic        exp_mic;
		logic        exp_scr;
	} row_t;

	`include "tb_zx_mem_table.svh"

	logic        clk_sys = 1'b0;
	logic        reset;
	logic [15:0] addr;
	logic [7:0]  data;
	logic        mreq;
	logic        iorq;
	logic        rd;
	logic        wr;
	logic        m1;
	model_t      model;
	phys_addr_t  ram_addr;
	logic        ram_rd;
	logic        ram_we;
	logic        page_scr;
	logic [2:0]  border;
	logic        ear;
	logic        mic;

	int row_errs;
	int pass_rows;
	int fail_rows;
	int cycle_count;
	int cycle_limit;

	always #4 clk_sys = ~clk_sys;

	zx_mem_top dut_i (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.addr     (addr),
		.data     (data),
		.mreq     (mreq),
		.iorq     (iorq),
		.rd       (rd),
		.wr       (wr),
		.m1       (m1),
		.model    (model),
		.ram_addr (ram_addr),
		.ram_rd   (ram_rd),
		.ram_we   (ram_we),
		.page_scr (page_scr),
		.border   (border),
		.ear      (ear),
		.mic      (mic)
	);

	//==================================================
	// Bus driving
	//==================================================

	// Strobe levels for one CPU cycle type
	task automatic drive_bus(cyc_t cyc, logic [15:0] a, logic [7:0] d);
		addr <= a;
		data <= d;
		mreq <= (cyc == cyc_mem_rd) || (cyc == cyc_mem_wr);
		iorq <= (cyc == cyc_io_wr);
		rd   <= (cyc == cyc_mem_rd);
		wr   <= (cyc == cyc_mem_wr) || (cyc == cyc_io_wr);
		m1   <= 1'b0; // No opcode fetches in this table
	endtask

	// Model only changes while reset is high
	task automatic apply_reset(model_t m);
		@(posedge clk_sys);
		reset <= 1'b1;
		model <= m;
		drive_bus(cyc_idle, 16'h0000, 8'h00);
		repeat (10) @(posedge clk_sys);
		reset <= 1'b0;
	endtask

	//==================================================
	// Checks
	//==================================================

	task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
		assert (got === exp) else begin
			$display("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
			row_errs++;
		end
	endtask

	// Hold 4 cycles, check in the last, then 1 idle cycle
	task automatic run_row(int idx);
		row_t r;
		logic is_mem;
		r = ROWS[idx];
		is_mem = (r.cyc == cyc_mem_rd) || (r.cyc == cyc_mem_wr);
		row_errs = 0;
		if (r.do_reset) begin
			apply_reset(r.model);
		end
		@(posedge clk_sys);
		drive_bus(r.cyc, r.addr, r.data);
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys); // Outputs settled
		if (is_mem) begin
			check_value("ram_addr", 32'(ram_addr), 32'(r.exp_addr));
		end
		check_value("ram_rd", 32'(ram_rd), 32'(r.cyc == cyc_mem_rd));
		check_value("ram_we", 32'(ram_we), 32'(r.exp_we));
		check_value("border", 32'(border), 32'(r.exp_border));
		check_value("ear", 32'(ear), 32'(r.exp_ear));
		check_value("mic", 32'(mic), 32'(r.exp_mic));
		check_value("page_scr", 32'(page_scr), 32'(r.exp_scr));
		if (row_errs == 0) begin
			pass_rows++;
			$display("row %0d ok", idx);
		end else begin
			fail_rows++;
			$display("row %0d failed with %0d wrong outputs", idx, row_errs);
		end
		@(posedge clk_sys);
		drive_bus(cyc_idle, r.addr, 8'h00);
	endtask

	function automatic int count_resets();
		int n;
		n = 0;
		for (int i = 0; i < NUM_ROWS; i++) begin
			if (ROWS[i].do_reset) begin
				n++;
			end
		end
		return n;
	endfunction

	//==================================================
	// Main sequence
	//==================================================

	initial begin
		pass_rows = 0;
		fail_rows = 0;
		reset <= 1'b1; // Held from time 0
		model <= model_128;
		drive_bus(cyc_idle, 16'h0000, 8'h00);
		for (int i = 0; i < NUM_ROWS; i++) begin
			run_row(i);
		end
		$display("rows %0d, passed %0d, failed %0d", NUM_ROWS, pass_rows, fail_rows);
		if (fail_rows == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	// 5 cycles per row, 11 per reset, plus margin
	initial begin
		cycle_limit = NUM_ROWS * 5 + 11 * count_resets() + 50;
		cycle_count = 0;
		while (cycle_count < cycle_limit) begin
			@(posedge clk_sys);
			cycle_count++;
		end
		$display("Run did not finish within %0d cycles", cycle_limit);
		$display("Test failures found");
		$finish;
	end

endmodule

/* zx_bus_decode.sv */
// One write per rising edge of iorq&wr&~m1; I/O reads and the +3 FDC ports are not decoded
`timescale 1ns/1ns

module zx_bus_decode import zx_io_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic [15:0] addr,
	input  logic [7:0]  data,
	input  logic        iorq,
	input  logic        wr,
	input  logic        m1,
	input  model_t      model,
	output logic        wr_7ffd,
	output logic        wr_1ffd,
	output logic        wr_fe,
	output logic [7:0]  port_data
);

	logic io_wr;      // Write level from the bus
	logic io_wr_d;    // Level one cycle back
	logic io_wr_rise;
	logic sel_fe;
	logic sel_7ffd;
	logic sel_1ffd;
	logic is_plus3;

	//==================================================
	// Cycle detect
	//==================================================

	assign io_wr      = iorq & wr & ~m1; // No M1, so not an interrupt ack
	assign io_wr_rise = io_wr & ~io_wr_d;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_d <= 1'b0;
		end else begin
			io_wr_d <= io_wr;
		end
	end

	//==================================================
	// Port select
	//==================================================

	assign is_plus3 = (model == model_plus3);

	assign sel_fe   = (addr & PORT_FE_MASK) == PORT_FE_MATCH;
	// On the +3 A14 splits 7FFD from 1FFD and the FDC ports
	assign sel_7ffd = ((addr & PORT_7FFD_MASK) == PORT_7FFD_MATCH)
		& (addr[PORT_7FFD_A14] | ~is_plus3);
	assign sel_1ffd = ((addr & PORT_1FFD_MASK) == PORT_1FFD_MATCH) & is_plus3;

	// Strobes last one cycle; FE and 7FFD may fire together
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_fe   <= 1'b0;
			wr_7ffd <= 1'b0;
			wr_1ffd <= 1'b0;
		end else begin
			wr_fe   <= io_wr_rise & sel_fe;
			wr_7ffd <= io_wr_rise & sel_7ffd;
			wr_1ffd <= io_wr_rise & sel_1ffd;
		end
	end

	// Byte held until the next write
	always_ff @(posedge clk_sys) begin
		if (io_wr_rise) begin
			port_data <= data;
		end
	end

endmodule

/* zx_io_pkg.sv */
// CPU I/O side of the 48K, 128K/+2 and +3 machines only; the unused enum code 3 acts as 128K
package zx_io_pkg;

	//==================================================
	// Machine model
	//==================================================

	// Must stay stable while reset is low
	typedef enum logic [1:0] {
		model_48    = 2'd0,
		model_128   = 2'd1,
		model_plus3 = 2'd2
	} model_t;

	//==================================================
	// Port decode, partial address match
	//==================================================

	localparam logic [15:0] PORT_FE_MASK    = 16'h0001; // ULA, any even port
	localparam logic [15:0] PORT_FE_MATCH   = 16'h0000;
	localparam logic [15:0] PORT_7FFD_MASK  = 16'h8002; // A15 and A1 low
	localparam logic [15:0] PORT_7FFD_MATCH = 16'h0000;
	localparam logic [15:0] PORT_1FFD_MASK  = 16'hF002; // +3 only
	localparam logic [15:0] PORT_1FFD_MATCH = 16'h1000;
	localparam int          PORT_7FFD_A14   = 14;       // Needed high on the +3

	//==================================================
	// Register bit positions
	//==================================================

	// 7FFD
	localparam int PG_RAM_LSB  = 0; // 3-bit page for slot 3
	localparam int PG_SCR_BIT  = 3;
	localparam int PG_ROM_BIT  = 4;
	localparam int PG_LOCK_BIT = 5;

	// 1FFD
	localparam int P3_SPECIAL_BIT = 0;
	localparam int P3_CFG_LSB     = 1; // 2-bit special layout
	localparam int P3_ROM_HI_BIT  = 2; // Shares bit 2 with the layout field

	// FE
	localparam int FE_BORDER_LSB = 0;
	localparam int FE_MIC_BIT    = 3;
	localparam int FE_EAR_BIT    = 4;

endpackage

/* zx_mem_map.sv */
// Paging is taken in the same cycle as the bus; no shadow, TR-DOS, MF128 or +D ROM overlays
`timescale 1ns/1ns

module zx_mem_map import zx_io_pkg::*, zx_mem_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic [15:0] addr,
	input  logic        mreq,
	input  logic        rd,
	input  logic        wr,
	input  model_t      model,
	input  logic [7:0]  page_reg,
	input  logic [7:0]  page_reg_plus3,
	output phys_addr_t  ram_addr,
	output logic        ram_rd,
	output logic        ram_we,
	output logic        page_scr
);

	logic [1:0] slot;       // CPU 16K slot
	logic       special;    // +3 all-RAM mode
	logic [1:0] layout;
	logic       is_rom;
	rom_bank_t  rom_bank;
	ram_page_t  ram_page;
	page_idx_t  page_idx;

	assign slot    = addr[15:14];
	assign special = (model == model_plus3) & page_reg_plus3[P3_SPECIAL_BIT];
	assign layout  = page_reg_plus3[P3_CFG_LSB +: 2];
	assign is_rom  = ~special & (slot == 2'd0);

	//==================================================
	// ROM bank
	//==================================================

	always_comb begin
		case (model)
			model_48:    rom_bank = ROM_BANK_48;
			model_plus3: rom_bank = {page_reg_plus3[P3_ROM_HI_BIT], page_reg[PG_ROM_BIT]};
			default:     rom_bank = {1'b0, page_reg[PG_ROM_BIT]}; // 128K/+2
		endcase
	end

	//==================================================
	// RAM page per slot
	//==================================================

	always_comb begin
		if (special) begin
			ram_page = SPECIAL_LAYOUT[layout][slot];
		end else begin
			case (slot)
				2'd1:    ram_page = SLOT1_PAGE;
				2'd2:    ram_page = SLOT2_PAGE;
				2'd3:    ram_page = page_reg[PG_RAM_LSB +: 3];
				default: ram_page = 3'd0; // ROM slot, page unused
			endcase
		end
	end

	// ROM banks sit above all RAM
	assign page_idx = is_rom ? (ROM_BASE_PAGE + {4'd0, rom_bank})
		: {3'd0, ram_page};

	//==================================================
	// Registered memory request
	//==================================================

	always_ff @(posedge clk_sys) begin
		ram_addr <= {page_idx, addr[PAGE_AW-1:0]};
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ram_rd   <= 1'b0;
			ram_we   <= 1'b0;
			page_scr <= 1'b0;
		end else begin
			ram_rd   <= mreq & rd;
			ram_we   <= mreq & wr & ~is_rom; // ROM is write protected
			page_scr <= page_reg[PG_SCR_BIT]; // Screen 0 or 1 for video
		end
	end

endmodule

/* zx_mem_pkg.sv */
// Physical map of 16K pages; RAM pages 0..7 at n*16K and four ROM banks at 0x80000, no 1024K
package zx_mem_pkg;

	//==================================================
	// Widths
	//==================================================

	localparam int PHYS_AW    = 20;               // Physical address width
	localparam int PAGE_AW    = 14;               // Offset inside a 16K page
	localparam int PAGE_IDX_W = PHYS_AW - PAGE_AW; // 16K page index

	typedef logic [PHYS_AW-1:0]    phys_addr_t;
	typedef logic [PAGE_IDX_W-1:0] page_idx_t;

	typedef logic [2:0] ram_page_t; // 128K of RAM
	typedef logic [1:0] rom_bank_t; // Up to 64K of ROM

	//==================================================
	// ROM placement
	//==================================================

	// Bank 0 starts at 0x80000
	localparam page_idx_t ROM_BASE_PAGE = 6'd32;

	//==================================================
	// +3 all-RAM layouts
	//==================================================

	// Row is the 1FFD layout field, column the CPU slot
	localparam ram_page_t SPECIAL_LAYOUT [4][4] = '{
		'{3'd0, 3'd1, 3'd2, 3'd3},
		'{3'd4, 3'd5, 3'd6, 3'd7},
		'{3'd4, 3'd5, 3'd6, 3'd3},
		'{3'd4, 3'd7, 3'd6, 3'd3}
	};

	// Fixed pages of the normal map
	localparam ram_page_t SLOT1_PAGE = 3'd5; // Screen 0
	localparam ram_page_t SLOT2_PAGE = 3'd2;

	// Bank forced on the 48K model
	localparam rom_bank_t ROM_BANK_48 = 2'd1;

endpackage

/* zx_mem_top.sv */
// Active-high CPU strobes, no wait states; model may change only while reset is high
`timescale 1ns/1ns

module zx_mem_top import zx_io_pkg::*, zx_mem_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic [15:0] addr,
	input  logic [7:0]  data,
	input  logic        mreq,
	input  logic        iorq,
	input  logic        rd,
	input  logic        wr,
	input  logic        m1,
	input  model_t      model,
	output phys_addr_t  ram_addr,
	output logic        ram_rd,
	output logic        ram_we,
	output logic        page_scr,
	output logic [2:0]  border,
	output logic        ear,
	output logic        mic
);

	logic       wr_7ffd;
	logic       wr_1ffd;
	logic       wr_fe;
	logic [7:0] port_data;
	logic [7:0] page_reg;
	logic [7:0] page_reg_plus3;

	//==================================================
	// I/O write decode, then port registers
	//==================================================

	zx_bus_decode bus_decode_i (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.addr      (addr),
		.data      (data),
		.iorq      (iorq),
		.wr        (wr),
		.m1        (m1),
		.model     (model),
		.wr_7ffd   (wr_7ffd),
		.wr_1ffd   (wr_1ffd),
		.wr_fe     (wr_fe),
		.port_data (port_data)
	);

	zx_port_regs port_regs_i (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.model          (model),
		.wr_7ffd        (wr_7ffd),
		.wr_1ffd        (wr_1ffd),
		.wr_fe          (wr_fe),
		.port_data      (port_data),
		.page_reg       (page_reg),
		.page_reg_plus3 (page_reg_plus3),
		.border         (border),
		.ear            (ear),
		.mic            (mic)
	);

	// Memory side sees the raw bus
	zx_mem_map mem_map_i (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.addr           (addr),
		.mreq           (mreq),
		.rd             (rd),
		.wr             (wr),
		.model          (model),
		.page_reg       (page_reg),
		.page_reg_plus3 (page_reg_plus3),
		.ram_addr       (ram_addr),
		.ram_rd         (ram_rd),
		.ram_we         (ram_we),
		.page_scr       (page_scr)
	);

endmodule

/* zx_port_regs.sv */
// Paging lock is released only by reset; no read-back of 7FFD or 1FFD is provided
`timescale 1ns/1ns

module zx_port_regs import zx_io_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  model_t     model,
	input  logic       wr_7ffd,
	input  logic       wr_1ffd,
	input  logic       wr_fe,
	input  logic [7:0] port_data,
	output logic [7:0] page_reg,
	output logic [7:0] page_reg_plus3,
	output logic [2:0] border,
	output logic       ear,
	output logic       mic
);

	logic page_lock;

	//==================================================
	// Paging lock
	//==================================================

	// 48K never pages; 128K and +3 lock once bit 5 is written
	assign page_lock = (model == model_48) | page_reg[PG_LOCK_BIT];

	//==================================================
	// 7FFD
	//==================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			page_reg <= 8'h00;
		end else if (wr_7ffd && !page_lock) begin
			page_reg <= port_data; // Lock bit included
		end
	end

	//==================================================
	// 1FFD
	//==================================================

	// Shares the 7FFD lock
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			page_reg_plus3 <= 8'h00;
		end else if (wr_1ffd && !page_lock) begin
			page_reg_plus3 <= port_data;
		end
	end

	//==================================================
	// ULA port FE
	//==================================================

	// Never locked
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			border <= 3'd0;
			ear    <= 1'b0;
			mic    <= 1'b0;
		end else if (wr_fe) begin
			border <= port_data[FE_BORDER_LSB +: 3];
			ear    <= port_data[FE_EAR_BIT];
			mic    <= port_data[FE_MIC_BIT];
		end
	end

endmodule
